// ==== design/pkt_pkg.sv ====
package pkt_pkg;

    // stream word layout
    localparam int DATA_W = 32;
    localparam int KEEP_W = DATA_W / 8;   // one enable per byte
    localparam int IDX_W  = 16;           // word index and frame length
    localparam int TAG_W  = 16;           // user pattern field

    // measurement counters
    localparam int CNT_W = 16;
    localparam logic [CNT_W-1:0] LAT_MAX = '1;   // latency sticks here

    // latency meter FSM encoding
    localparam logic [1:0] ST_IDLE   = 2'd0;
    localparam logic [1:0] ST_TIMING = 2'd1;
    localparam logic [1:0] ST_DONE   = 2'd2;

    // The high half of every word carries the pattern and the low half
    // carries the position of the word inside its frame.
    typedef struct packed {
        logic [TAG_W-1:0] tag;   // user pattern
        logic [IDX_W-1:0] idx;   // word index
    } pkt_fields_t;

    // one stream word, seen either as a plain bus or as its two fields
    typedef union packed {
        logic [DATA_W-1:0] raw;
        pkt_fields_t       fields;
    } pkt_word_u;

endpackage

// ==== design/frame_report_if.sv ====
`timescale 1ns/100ps

// per-frame result from the receive monitor to the latency meter
interface frame_report_if import pkt_pkg::*; ();

    logic             rx_first;     // index 0 word on the receive stream
    logic             frame_done;   // one cycle after the frame closes
    logic             frame_ok;     // valid with frame_done
    logic [IDX_W-1:0] frame_len;    // last index of the closed frame

    modport src (
        output rx_first,
        output frame_done,
        output frame_ok,
        output frame_len
    );

    modport snk (
        input rx_first,
        input frame_done,
        input frame_ok,
        input frame_len
    );

endinterface

// ==== design/frame_gen.sv ====
`timescale 1ns/100ps

module frame_gen import pkt_pkg::*; (
    input  logic              s00_axis_aclk,
    input  logic              packet_gen_reset,
    input  logic [IDX_W-1:0]  i_packet_length,
    input  logic [TAG_W-1:0]  i_pattern,
    input  logic              i_tx_tready,
    output pkt_word_u         o_tx_tdata,
    output logic [KEEP_W-1:0] o_tx_tkeep,
    output logic              o_tx_tvalid,
    output logic              o_tx_tlast,
    output logic              o_tx_start
);

    logic [IDX_W-1:0] idx_q;     // index of the word on the bus
    logic [IDX_W-1:0] len_q;     // length of the frame in flight
    logic [TAG_W-1:0] tag_q;     // pattern of the frame in flight
    logic             valid_q;
    logic             at_first;
    logic [IDX_W-1:0] cur_len;
    logic             xfer;

    assign at_first = idx_q == '0;
    assign cur_len  = at_first ? i_packet_length : len_q;   // live until index 0 leaves
    assign xfer     = valid_q && i_tx_tready;

    always_comb begin
        o_tx_tdata.fields.tag = at_first ? i_pattern : tag_q;
        o_tx_tdata.fields.idx = idx_q;
    end

    assign o_tx_tkeep  = '1;   // full words only
    assign o_tx_tvalid = valid_q;
    assign o_tx_tlast  = idx_q == cur_len;
    assign o_tx_start  = xfer && at_first;

    always_ff @(posedge s00_axis_aclk) begin
        if (packet_gen_reset) begin
            valid_q <= 1'b0;
            idx_q   <= '0;
        end else begin
            valid_q <= 1'b1;   // free running after reset
            if (xfer) begin
                idx_q <= o_tx_tlast ? '0 : idx_q + 1'b1;
            end
        end
    end

    // settings are frozen for the rest of the frame once index 0 is taken
    always_ff @(posedge s00_axis_aclk) begin
        if (xfer && at_first) begin
            len_q <= i_packet_length;
            tag_q <= i_pattern;
        end
    end

endmodule

// ==== design/frame_monitor.sv ====
`timescale 1ns/100ps

module frame_monitor import pkt_pkg::*; (
    input  logic              s00_axis_aclk,
    input  logic              packet_gen_reset,
    input  logic [IDX_W-1:0]  i_packet_length,
    input  logic [TAG_W-1:0]  i_pattern,
    input  pkt_word_u         i_rx_tdata,
    input  logic [KEEP_W-1:0] i_rx_tkeep,
    input  logic              i_rx_tvalid,
    input  logic              i_rx_tlast,
    input  logic              i_rx_tuser,
    frame_report_if.src       o_report
);

    logic             active_q;    // between index 0 and tlast
    logic [IDX_W-1:0] exp_idx_q;   // position of the next word
    logic [IDX_W-1:0] len_q;
    logic [TAG_W-1:0] tag_q;
    logic             err_q;       // fault seen earlier in this frame
    logic             done_q;
    logic             ok_q;
    logic [IDX_W-1:0] flen_q;

    logic             start_word;
    logic             abort;
    logic             tracking;
    logic             end_frame;
    logic [IDX_W-1:0] cur_pos;
    logic [IDX_W-1:0] cur_len;
    logic [TAG_W-1:0] cur_tag;
    logic             prev_err;
    logic             word_bad;

    assign start_word = i_rx_tvalid && (i_rx_tdata.fields.idx == '0);
    assign abort      = start_word && active_q;   // index 0 inside a frame
    assign tracking   = i_rx_tvalid && (active_q || start_word);
    assign end_frame  = tracking && i_rx_tlast;

    // an index 0 word opens a new frame with the current settings
    always_comb begin
        cur_pos  = start_word ? '0 : exp_idx_q;
        cur_len  = start_word ? i_packet_length : len_q;
        cur_tag  = start_word ? i_pattern : tag_q;
        prev_err = start_word ? 1'b0 : err_q;
        word_bad = (i_rx_tdata.fields.idx != cur_pos)
                || (i_rx_tdata.fields.tag != cur_tag)
                || (i_rx_tkeep != '1)
                || i_rx_tuser
                || (i_rx_tlast != (cur_pos == cur_len));   // tlast in the wrong place
    end

    // Words outside a frame are dropped until the next index 0, so an
    // early tlast costs one bad frame and then tracking realigns.
    always_ff @(posedge s00_axis_aclk) begin
        if (packet_gen_reset) begin
            active_q <= 1'b0;
            done_q   <= 1'b0;
        end else begin
            done_q <= abort || end_frame;
            if (tracking) begin
                active_q <= !i_rx_tlast;
            end
        end
    end

    always_ff @(posedge s00_axis_aclk) begin
        if (start_word) begin
            len_q <= i_packet_length;
            tag_q <= i_pattern;
        end
        if (tracking) begin
            exp_idx_q <= cur_pos + 1'b1;
            err_q     <= prev_err || word_bad;
        end
        // an aborted frame is reported in place of a one-word frame on the same edge
        ok_q   <= !abort && !prev_err && !word_bad;
        flen_q <= abort ? exp_idx_q - 1'b1 : cur_pos;
    end

    assign o_report.rx_first   = start_word;
    assign o_report.frame_done = done_q;
    assign o_report.frame_ok   = ok_q;
    assign o_report.frame_len  = flen_q;

endmodule

// ==== design/latency_meter.sv ====
`timescale 1ns/100ps

module latency_meter import pkt_pkg::*; (
    input  logic             s00_axis_aclk,
    input  logic             packet_gen_reset,
    input  logic             i_tx_start,
    frame_report_if.snk      i_report,
    output logic [CNT_W-1:0] o_latency,
    output logic             o_latency_done,
    output logic [CNT_W-1:0] o_frames_ok,
    output logic [CNT_W-1:0] o_frames_bad
);

    logic [1:0]       state_q;
    logic [CNT_W-1:0] lat_q;       // cycles since the first tx start
    logic [CNT_W-1:0] ok_cnt_q;
    logic [CNT_W-1:0] bad_cnt_q;

    // one measurement per reset, first tx frame to first rx frame
    always_ff @(posedge s00_axis_aclk) begin
        if (packet_gen_reset) begin
            state_q <= ST_IDLE;
            lat_q   <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (i_tx_start) begin
                        // both starts on one edge means zero latency
                        lat_q   <= i_report.rx_first ? '0 : CNT_W'(1);
                        state_q <= i_report.rx_first ? ST_DONE : ST_TIMING;
                    end
                end
                ST_TIMING: begin
                    if (i_report.rx_first) begin
                        state_q <= ST_DONE;
                    end else if (lat_q != LAT_MAX) begin
                        lat_q <= lat_q + 1'b1;   // saturate
                    end
                end
                default: state_q <= state_q;   // done holds until reset
            endcase
        end
    end

    // frame counters wrap
    always_ff @(posedge s00_axis_aclk) begin
        if (packet_gen_reset) begin
            ok_cnt_q  <= '0;
            bad_cnt_q <= '0;
        end else if (i_report.frame_done) begin
            if (i_report.frame_ok) begin
                ok_cnt_q <= ok_cnt_q + 1'b1;
            end else begin
                bad_cnt_q <= bad_cnt_q + 1'b1;
            end
        end
    end

    assign o_latency      = lat_q;
    assign o_latency_done = state_q == ST_DONE;
    assign o_frames_ok    = ok_cnt_q;
    assign o_frames_bad   = bad_cnt_q;

endmodule

// ==== design/traffic_top.sv ====
`timescale 1ns/100ps

module traffic_top import pkt_pkg::*; (
    input  logic              s00_axis_aclk,
    input  logic              packet_gen_reset,
    input  logic [IDX_W-1:0]  i_packet_length,
    input  logic [TAG_W-1:0]  i_pattern,

    // transmit stream
    output logic [DATA_W-1:0] o_tx_tdata,
    output logic [KEEP_W-1:0] o_tx_tkeep,
    output logic              o_tx_tvalid,
    output logic              o_tx_tlast,
    input  logic              i_tx_tready,

    // receive stream, no back-pressure
    input  logic [DATA_W-1:0] i_rx_tdata,
    input  logic [KEEP_W-1:0] i_rx_tkeep,
    input  logic              i_rx_tvalid,
    input  logic              i_rx_tlast,
    input  logic              i_rx_tuser,

    // measurement results
    output logic [CNT_W-1:0]  o_latency,
    output logic              o_latency_done,
    output logic [CNT_W-1:0]  o_frames_ok,
    output logic [CNT_W-1:0]  o_frames_bad
);

    pkt_word_u tx_word;
    pkt_word_u rx_word;
    logic      tx_start;   // index 0 transfer strobe

    frame_report_if report_if ();

    assign o_tx_tdata  = tx_word.raw;
    assign rx_word.raw = i_rx_tdata;

    frame_gen frame_gen_inst (
        .s00_axis_aclk    (s00_axis_aclk),
        .packet_gen_reset (packet_gen_reset),
        .i_packet_length  (i_packet_length),
        .i_pattern        (i_pattern),
        .i_tx_tready      (i_tx_tready),
        .o_tx_tdata       (tx_word),
        .o_tx_tkeep       (o_tx_tkeep),
        .o_tx_tvalid      (o_tx_tvalid),
        .o_tx_tlast       (o_tx_tlast),
        .o_tx_start       (tx_start)
    );

    frame_monitor frame_monitor_inst (
        .s00_axis_aclk    (s00_axis_aclk),
        .packet_gen_reset (packet_gen_reset),
        .i_packet_length  (i_packet_length),
        .i_pattern        (i_pattern),
        .i_rx_tdata       (rx_word),
        .i_rx_tkeep       (i_rx_tkeep),
        .i_rx_tvalid      (i_rx_tvalid),
        .i_rx_tlast       (i_rx_tlast),
        .i_rx_tuser       (i_rx_tuser),
        .o_report         (report_if.src)
    );

    latency_meter latency_meter_inst (
        .s00_axis_aclk    (s00_axis_aclk),
        .packet_gen_reset (packet_gen_reset),
        .i_tx_start       (tx_start),
        .i_report         (report_if.snk),
        .o_latency        (o_latency),
        .o_latency_done   (o_latency_done),
        .o_frames_ok      (o_frames_ok),
        .o_frames_bad     (o_frames_bad)
    );

endmodule

// ==== verif/tb_traffic_top.sv ====
`timescale 1ns/100ps

module tb_traffic_top import pkt_pkg::*; ();

    localparam int          LOOP_D    = 6;      // loopback delay in cycles
    localparam int          TIMEOUT   = 2000;   // cycles allowed per wait loop
    localparam int          CLEAN_K   = 5;
    localparam logic [15:0] INJ_IDX   = 16'd3;  // word that carries a fault
    localparam logic [31:0] RAND_SEED = 32'heb776d80;
    localparam int          PIPE_W    = DATA_W + KEEP_W + 3;

    logic              s00_axis_aclk;
    logic              packet_gen_reset = 1'b1;
    logic [IDX_W-1:0]  packet_length    = 16'd7;
    logic [TAG_W-1:0]  pattern          = 16'ha5c3;
    logic              tx_ready         = 1'b0;
    logic [DATA_W-1:0] rx_data          = '0;
    logic [KEEP_W-1:0] rx_keep          = '0;
    logic              rx_valid         = 1'b0;
    logic              rx_last          = 1'b0;
    logic              rx_user          = 1'b0;

    wire [DATA_W-1:0] tx_data;
    wire [KEEP_W-1:0] tx_keep;
    wire              tx_valid;
    wire              tx_last;
    wire [CNT_W-1:0]  latency;
    wire              latency_done;
    wire [CNT_W-1:0]  frames_ok;
    wire [CNT_W-1:0]  frames_bad;

    logic [PIPE_W-1:0] pipe [LOOP_D-1];   // {valid, user, last, keep, data}
    logic [2:0]        inj_mode = '0;     // 1 index, 2 tag, 3 tuser, 4 early tlast
    logic [7:0]        inj_req  = '0;
    logic [7:0]        inj_done = '0;
    int                errors   = 0;
    int                checks   = 0;
    int unsigned       seed_val;

    traffic_top traffic_top_inst (
        .s00_axis_aclk    (s00_axis_aclk),
        .packet_gen_reset (packet_gen_reset),
        .i_packet_length  (packet_length),
        .i_pattern        (pattern),
        .o_tx_tdata       (tx_data),
        .o_tx_tkeep       (tx_keep),
        .o_tx_tvalid      (tx_valid),
        .o_tx_tlast       (tx_last),
        .i_tx_tready      (tx_ready),
        .i_rx_tdata       (rx_data),
        .i_rx_tkeep       (rx_keep),
        .i_rx_tvalid      (rx_valid),
        .i_rx_tlast       (rx_last),
        .i_rx_tuser       (rx_user),
        .o_latency        (latency),
        .o_latency_done   (latency_done),
        .o_frames_ok      (frames_ok),
        .o_frames_bad     (frames_bad)
    );

    initial begin
        s00_axis_aclk = 1'b0;
        forever #5 s00_axis_aclk = ~s00_axis_aclk;
    end

    // loopback, a transfer at edge N reaches the monitor at edge N+LOOP_D
    always @(posedge s00_axis_aclk) begin
        logic [PIPE_W-1:0] cap;
        if (packet_gen_reset) begin
            for (int i = 0; i < LOOP_D - 1; i++) begin
                pipe[i] <= '0;   // flush words from before reset
            end
            rx_valid <= 1'b0;
            rx_last  <= 1'b0;
            rx_user  <= 1'b0;
        end else begin
            cap = {tx_valid && tx_ready, 1'b0, tx_last, tx_keep, tx_data};
            if (cap[PIPE_W-1] && inj_req != inj_done && tx_data[15:0] == INJ_IDX) begin
                case (inj_mode)
                    3'd1:    cap[8]  = ~cap[8];    // index bit
                    3'd2:    cap[16] = ~cap[16];   // tag bit
                    3'd3:    cap[PIPE_W-2] = 1'b1; // tuser
                    default: cap[PIPE_W-3] = 1'b1; // tlast before the end
                endcase
                inj_done <= inj_done + 1'b1;
            end
            pipe[0] <= cap;
            for (int i = 1; i < LOOP_D - 1; i++) begin
                pipe[i] <= pipe[i-1];
            end
            {rx_valid, rx_user, rx_last, rx_keep, rx_data} <= pipe[LOOP_D-2];
        end
    end

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] want);
        checks++;
        assert (got === want) else begin
            errors++;
            $display("ERROR %s got 0x%08h expected 0x%08h", name, got, want);
        end
    endtask

    task automatic check_wait(input bit ok, input string what);
        checks++;
        assert (ok) else begin
            errors++;
            $display("timeout while %s", what);
        end
    endtask

    task automatic do_reset();
        @(posedge s00_axis_aclk);
        packet_gen_reset <= 1'b1;
        tx_ready         <= 1'b0;
        repeat (10) @(posedge s00_axis_aclk);
        packet_gen_reset <= 1'b0;
        @(negedge s00_axis_aclk);
    endtask

    // runs n frames, then parks the generator on the next index 0 word
    task automatic run_frames(input int n, input bit stall);
        int               frames;
        int               cycles;
        logic [IDX_W-1:0] exp_idx;
        logic [31:0]      held;
        bit               stalled;
        frames  = 0;
        cycles  = 0;
        exp_idx = '0;
        held    = '0;
        stalled = 1'b0;
        while (frames < n && cycles < TIMEOUT) begin
            @(posedge s00_axis_aclk);
            tx_ready <= stall ? (($urandom % 4) != 0) : 1'b1;
            @(negedge s00_axis_aclk);
            cycles++;
            if (stalled) begin
                check_val("o_tx_tdata (stalled)", tx_data, held);
            end
            if (tx_valid) begin
                check_val("o_tx_tdata", tx_data, {pattern, exp_idx});
                check_val("o_tx_tkeep", 32'(tx_keep), 32'hf);
                check_val("o_tx_tlast", 32'(tx_last), 32'(exp_idx == packet_length));
                stalled = !tx_ready;
                held    = tx_data;
                if (tx_ready) begin
                    exp_idx = (exp_idx == packet_length) ? '0 : exp_idx + 1'b1;
                    if (exp_idx == '0) begin
                        frames++;
                    end
                end
            end
        end
        check_wait(frames == n, "running frames on the transmit stream");
        @(posedge s00_axis_aclk);
        tx_ready <= 1'b0;
    endtask

    // fixed by the loop delay plus the two cycle count update
    task automatic drain();
        repeat (LOOP_D + 3) @(negedge s00_axis_aclk);
    endtask

    task automatic check_reset_state();
        do_reset();
        check_val("o_tx_tvalid", 32'(tx_valid), 0);
        check_val("o_latency_done", 32'(latency_done), 0);
        check_val("o_latency", 32'(latency), 0);
        check_val("o_frames_ok", 32'(frames_ok), 0);
        check_val("o_frames_bad", 32'(frames_bad), 0);
    endtask

    task automatic frame_format_under_stall();
        run_frames(4, 1'b1);
        drain();
        check_val("o_frames_bad", 32'(frames_bad), 0);
    endtask

    task automatic measure_latency();
        int cycles;
        check_reset_state();   // clears the counts and latency of the first test
        run_frames(2, 1'b0);
        cycles = 0;
        while (!latency_done && cycles < TIMEOUT) begin
            @(negedge s00_axis_aclk);
            cycles++;
        end
        check_wait(latency_done, "waiting for the latency result");
        check_val("o_latency", 32'(latency), LOOP_D);
        run_frames(2, 1'b0);
        drain();
        check_val("o_latency", 32'(latency), LOOP_D);   // one measurement per reset
        check_val("o_latency_done", 32'(latency_done), 1);
    endtask

    task automatic count_clean_frames();
        logic [CNT_W-1:0] ok0;
        logic [CNT_W-1:0] bad0;
        drain();
        ok0  = frames_ok;
        bad0 = frames_bad;
        run_frames(CLEAN_K, 1'b0);
        drain();
        check_val("o_frames_ok", 32'(frames_ok), 32'(ok0) + CLEAN_K);
        check_val("o_frames_bad", 32'(frames_bad), 32'(bad0));
    endtask

    task automatic inject_errors();
        logic [CNT_W-1:0] ok0;
        logic [CNT_W-1:0] bad0;
        drain();
        ok0  = frames_ok;
        bad0 = frames_bad;
        for (int mode = 1; mode <= 4; mode++) begin
            @(posedge s00_axis_aclk);
            inj_mode <= 3'(mode);
            inj_req  <= inj_req + 1'b1;
            run_frames(1, 1'b0);
            check_val("inj_done", 32'(inj_done), 32'(inj_req));
        end
        run_frames(1, 1'b0);   // clean frame, monitor realigns on index 0
        drain();
        check_val("o_frames_bad", 32'(frames_bad), 32'(bad0) + 4);
        check_val("o_frames_ok", 32'(frames_ok), 32'(ok0) + 1);
    endtask

    task automatic change_length();
        logic [CNT_W-1:0] ok0;
        logic [CNT_W-1:0] bad0;
        drain();
        ok0  = frames_ok;
        bad0 = frames_bad;
        @(posedge s00_axis_aclk);
        packet_length <= 16'd2;
        pattern       <= 16'h3c5a;
        run_frames(3, 1'b1);
        drain();   // short frames must be home before the monitor sees a new length
        @(posedge s00_axis_aclk);
        packet_length <= 16'd12;
        run_frames(2, 1'b1);
        drain();
        check_val("o_frames_ok", 32'(frames_ok), 32'(ok0) + 5);
        check_val("o_frames_bad", 32'(frames_bad), 32'(bad0));
    endtask

    initial begin
        seed_val = $urandom(RAND_SEED);
        check_reset_state();
        frame_format_under_stall();
        measure_latency();
        count_clean_frames();
        inject_errors();
        change_length();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
design/pkt_pkg.sv
design/frame_report_if.sv
design/frame_gen.sv
design/frame_monitor.sv
design/latency_meter.sv
design/traffic_top.sv
verif/tb_traffic_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the traffic testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_traffic_top \
    -f sources.f \
    -o tb_traffic_top

OUTPUT=$(./obj_dir/tb_traffic_top)
echo "$OUTPUT"

if echo "$OUTPUT" | grep -q "TESTBENCH PASSED"; then
    exit 0
fi
exit 1
